// ==== logic/mini_core_macros.svh ====
`ifndef MINI_CORE_MACROS_SVH
`define MINI_CORE_MACROS_SVH

// ====================================================================
// tile sizing
// ====================================================================

// shared instr/data memory, in 32-bit words
`define MEM_DEPTH    256

// fabric response queue, power of two
`define RSP_Q_DEPTH  4

// ====================================================================
// fabric output flow control and control space
// ====================================================================

`define FAB_CREDITS  2     // credits held after reset

`define CTRL_ADDR    255   // word address of run register

`endif

// ==== logic/mini_core_pkg.sv ====
package mini_core_pkg;

// ====================================================================
// fabric transactions
// ====================================================================

typedef logic [3:0] tTileId;

typedef enum logic [1:0] {
   FAB_RD_REQ = 2'b00,   // read request
   FAB_WR_REQ = 2'b01,   // write request
   FAB_RD_RSP = 2'b10,   // read response, carries data
   FAB_WR_ACK = 2'b11    // write ack, echoes data
} tFabOpcode;

typedef struct packed {
   tFabOpcode   opcode;
   tTileId      srcId;
   tTileId      dstId;
   logic [31:0] address;   // word address
   logic [31:0] data;
} tTileTrans;

// core data port, byte addressed
typedef struct packed {
   logic [31:0] address;
   logic [31:0] wrData;
   logic [3:0]  byteEn;
   logic        wrEn;
   logic        rdEn;
} tCore2MemReq;

// ====================================================================
// rv32i subset encodings
// ====================================================================

typedef enum logic [6:0] {
   OP_LOAD   = 7'b0000011,
   OP_IMM    = 7'b0010011,
   OP_STORE  = 7'b0100011,
   OP_REG    = 7'b0110011,
   OP_BRANCH = 7'b1100011
} tRvOpcode;

typedef enum logic [2:0] {
   F3_ADD  = 3'b000,   // add, sub, addi
   F3_BNE  = 3'b001,
   F3_WORD = 3'b010    // lw, sw
} tFunct3;

typedef enum logic [6:0] {
   F7_BASE = 7'b0000000,
   F7_SUB  = 7'b0100000
} tFunct7;

typedef struct packed {
   tFunct7     funct7;
   logic [4:0] rs2;
   logic [4:0] rs1;
   tFunct3     funct3;
   logic [4:0] rd;
   tRvOpcode   opcode;
} tRType;

typedef struct packed {
   logic [11:0] imm12;   // i imm, or s/b upper imm over rs2
   logic [4:0]  rs1;
   tFunct3      funct3;
   logic [4:0]  immLo;   // rd, or s/b low imm
   tRvOpcode    opcode;
} tIsbType;

// same word, register view or immediate view
typedef union packed {
   tRType   rType;
   tIsbType isbType;
} tInstr;

endpackage

// ==== logic/mini_core.sv ====
module mini_core (
   input  logic                           Clock,
   input  logic                           rst,
   input  logic                           run,                  // from ctrl register
   // instruction fetch
   output logic                           readyQ101H,           // fetch enable
   output logic [31:0]                    pcQ100H,
   input  logic [31:0]                    preInstructionQ101H,
   // data access
   input  logic                           dMemReady,            // low while fabric owns port
   output mini_core_pkg::tCore2MemReq     core2DmemReqQ103H,
   input  logic [31:0]                    dMemRdRspQ104H
);

// ====================================================================
// pipeline state
// ====================================================================
logic        validQ101H;      // fetched word is live
logic [31:0] pcQ101H;         // pc of fetched word
logic        loadPendQ104H;   // load data on the bus now
logic [4:0]  rdQ104H;         // load target
logic [31:0] regFile [32];

mini_core_pkg::tInstr instrQ101H;

logic        execQ103H;       // instruction executes this cycle
logic        isAddi;
logic        isAdd;
logic        isSub;
logic        isLw;
logic        isSw;
logic        isBne;
logic [11:0] imm12Q103H;
logic [4:0]  immLoQ103H;
logic [31:0] immIQ103H;
logic [31:0] immSQ103H;
logic [31:0] immBQ103H;
logic [31:0] rs1ValQ103H;
logic [31:0] rs2ValQ103H;
logic [31:0] aluQ103H;
logic        aluWrQ103H;
logic        memStallQ103H;
logic        branchTakenQ103H;

// ====================================================================
// decode
// ====================================================================
assign instrQ101H = preInstructionQ101H;
assign execQ103H  = run && validQ101H && !loadPendQ104H;   // load writeback blocks issue

assign isAddi = (instrQ101H.rType.opcode == mini_core_pkg::OP_IMM)
             && (instrQ101H.rType.funct3 == mini_core_pkg::F3_ADD);
assign isAdd  = (instrQ101H.rType.opcode == mini_core_pkg::OP_REG)
             && (instrQ101H.rType.funct3 == mini_core_pkg::F3_ADD)
             && (instrQ101H.rType.funct7 == mini_core_pkg::F7_BASE);
assign isSub  = (instrQ101H.rType.opcode == mini_core_pkg::OP_REG)
             && (instrQ101H.rType.funct3 == mini_core_pkg::F3_ADD)
             && (instrQ101H.rType.funct7 == mini_core_pkg::F7_SUB);
assign isLw   = (instrQ101H.rType.opcode == mini_core_pkg::OP_LOAD)
             && (instrQ101H.rType.funct3 == mini_core_pkg::F3_WORD);
assign isSw   = (instrQ101H.rType.opcode == mini_core_pkg::OP_STORE)
             && (instrQ101H.rType.funct3 == mini_core_pkg::F3_WORD);
assign isBne  = (instrQ101H.rType.opcode == mini_core_pkg::OP_BRANCH)
             && (instrQ101H.rType.funct3 == mini_core_pkg::F3_BNE);

// immediates from the i/s/b view
assign imm12Q103H = instrQ101H.isbType.imm12;
assign immLoQ103H = instrQ101H.isbType.immLo;
assign immIQ103H  = {{20{imm12Q103H[11]}}, imm12Q103H};
assign immSQ103H  = {{20{imm12Q103H[11]}}, imm12Q103H[11:5], immLoQ103H};
assign immBQ103H  = {{19{imm12Q103H[11]}}, imm12Q103H[11], immLoQ103H[0],
                     imm12Q103H[10:5], immLoQ103H[4:1], 1'b0};

// register read, x0 hardwired
assign rs1ValQ103H = (instrQ101H.rType.rs1 == 5'd0) ? 32'd0 : regFile[instrQ101H.rType.rs1];
assign rs2ValQ103H = (instrQ101H.rType.rs2 == 5'd0) ? 32'd0 : regFile[instrQ101H.rType.rs2];

// ====================================================================
// execute, branch, data request
// ====================================================================
assign aluQ103H = isAddi ? (rs1ValQ103H + immIQ103H)
                : isSub  ? (rs1ValQ103H - rs2ValQ103H)
                :          (rs1ValQ103H + rs2ValQ103H);
assign aluWrQ103H = execQ103H && (isAdd || isSub || isAddi)
                 && (instrQ101H.rType.rd != 5'd0);

always_comb begin
   core2DmemReqQ103H.address = rs1ValQ103H + (isSw ? immSQ103H : immIQ103H);
   core2DmemReqQ103H.wrData  = rs2ValQ103H;
   core2DmemReqQ103H.byteEn  = 4'hF;                 // word accesses only
   core2DmemReqQ103H.wrEn    = execQ103H && isSw;
   core2DmemReqQ103H.rdEn    = execQ103H && isLw;
end

assign memStallQ103H    = execQ103H && (isLw || isSw) && !dMemReady;   // hold till granted
assign branchTakenQ103H = execQ103H && isBne && (rs1ValQ103H != rs2ValQ103H);
assign readyQ101H       = run && !loadPendQ104H && !memStallQ103H;

// ====================================================================
// pc and control
// ====================================================================
always_ff @(posedge Clock) begin
   if (rst) begin
      pcQ100H       <= 32'd0;
      validQ101H    <= 1'b0;
      loadPendQ104H <= 1'b0;
   end else begin
      loadPendQ104H <= execQ103H && isLw && dMemReady;
      if (branchTakenQ103H) begin
         pcQ100H    <= pcQ101H + immBQ103H;   // redirect
         validQ101H <= 1'b0;                  // drop word fetched behind bne
      end else if (readyQ101H) begin
         pcQ100H    <= pcQ100H + 32'd4;
         validQ101H <= 1'b1;
      end
   end
end

always_ff @(posedge Clock) begin
   if (readyQ101H) pcQ101H <= pcQ100H;        // tracks the fetch
   if (execQ103H && isLw) rdQ104H <= instrQ101H.rType.rd;
end

// writeback, load data wins its cycle
always_ff @(posedge Clock) begin
   if (loadPendQ104H) begin
      if (rdQ104H != 5'd0) regFile[rdQ104H] <= dMemRdRspQ104H;
   end else if (aluWrQ103H) begin
      regFile[instrQ101H.rType.rd] <= aluQ103H;
   end
end

endmodule

// ==== logic/mini_mem_wrap.sv ====
`include "mini_core_macros.svh"

module mini_mem_wrap (
   input  logic                           Clock,
   input  logic                           rst,
   input  mini_core_pkg::tTileId          localTileId,
   // core side
   input  logic                           readyQ101H,
   input  logic [31:0]                    pcQ100H,
   output logic [31:0]                    preInstructionQ101H,
   input  var mini_core_pkg::tCore2MemReq core2DmemReqQ103H,
   output logic [31:0]                    dMemRdRspQ104H,
   output logic                           dMemReady,
   output logic                           run,
   // fabric side
   input  logic                           inFabricValidQ503H,
   input  var mini_core_pkg::tTileTrans   inFabricQ503H,
   output logic                           miniCoreReady,
   output logic                           outFabricValidQ505H,
   output mini_core_pkg::tTileTrans       outFabricQ505H,
   input  logic                           fabCreditReturn
);

localparam int memIdxW = $clog2(`MEM_DEPTH);
localparam int qPtrW   = $clog2(`RSP_Q_DEPTH);
localparam int creditW = $clog2(`FAB_CREDITS + 1);
localparam logic [qPtrW:0] qFullMark = (qPtrW + 1)'(`RSP_Q_DEPTH - 1);   // stop accepting here

logic [31:0] mem [`MEM_DEPTH];

logic                     fabReqQ503H;    // accepted request for this tile
logic                     fabWrQ503H;
logic                     ctrlHitQ503H;   // aimed at run register
logic [memIdxW-1:0]       fabIdxQ503H;
logic [memIdxW-1:0]       coreIdxQ103H;
mini_core_pkg::tTileTrans rspQ503H;

mini_core_pkg::tTileTrans rspQ [`RSP_Q_DEPTH];
logic [qPtrW-1:0]         wrPtr;
logic [qPtrW-1:0]         rdPtr;
logic [qPtrW:0]           qCount;
logic [creditW-1:0]       credits;
logic                     popQ504H;

// ====================================================================
// fabric request decode
// ====================================================================
assign fabReqQ503H  = inFabricValidQ503H && miniCoreReady
                   && (inFabricQ503H.dstId == localTileId)
                   && ((inFabricQ503H.opcode == mini_core_pkg::FAB_RD_REQ)
                    || (inFabricQ503H.opcode == mini_core_pkg::FAB_WR_REQ));
assign fabWrQ503H   = fabReqQ503H && (inFabricQ503H.opcode == mini_core_pkg::FAB_WR_REQ);
assign ctrlHitQ503H = fabReqQ503H && (inFabricQ503H.address == `CTRL_ADDR);
assign fabIdxQ503H  = inFabricQ503H.address[memIdxW-1:0];          // fabric is word addressed
assign coreIdxQ103H = core2DmemReqQ103H.address[memIdxW+1:2];      // core is byte addressed

assign dMemReady = !fabReqQ503H;   // fabric owns the port this cycle

// response, ids swapped
always_comb begin
   rspQ503H.opcode  = fabWrQ503H ? mini_core_pkg::FAB_WR_ACK : mini_core_pkg::FAB_RD_RSP;
   rspQ503H.srcId   = inFabricQ503H.dstId;
   rspQ503H.dstId   = inFabricQ503H.srcId;
   rspQ503H.address = inFabricQ503H.address;
   if (fabWrQ503H) begin
      rspQ503H.data = inFabricQ503H.data;   // ack echoes the word
   end else if (ctrlHitQ503H) begin
      rspQ503H.data = {31'd0, run};
   end else begin
      rspQ503H.data = mem[fabIdxQ503H];
   end
end

// ====================================================================
// memory and run register
// ====================================================================
always_ff @(posedge Clock) begin
   if (fabWrQ503H && !ctrlHitQ503H) begin
      mem[fabIdxQ503H] <= inFabricQ503H.data;
   end else if (core2DmemReqQ103H.wrEn && dMemReady) begin
      for (int b = 0; b < 4; b++) begin
         if (core2DmemReqQ103H.byteEn[b]) begin
            mem[coreIdxQ103H][8*b +: 8] <= core2DmemReqQ103H.wrData[8*b +: 8];
         end
      end
   end
end

always_ff @(posedge Clock) begin
   if (readyQ101H) preInstructionQ101H <= mem[pcQ100H[memIdxW+1:2]];   // held on stall
   if (core2DmemReqQ103H.rdEn && dMemReady) dMemRdRspQ104H <= mem[coreIdxQ103H];
end

always_ff @(posedge Clock) begin
   if (rst) begin
      run <= 1'b0;                             // core parked at pc 0
   end else if (fabWrQ503H && ctrlHitQ503H) begin
      run <= inFabricQ503H.data[0];
   end
end

// ====================================================================
// response queue and output credits
// ====================================================================
assign popQ504H      = (qCount != '0) && (credits != '0);
assign miniCoreReady = qCount < qFullMark;

always_ff @(posedge Clock) begin
   if (fabReqQ503H) rspQ[wrPtr] <= rspQ503H;
   if (popQ504H) outFabricQ505H <= rspQ[rdPtr];
end

always_ff @(posedge Clock) begin
   if (rst) begin
      wrPtr               <= '0;
      rdPtr               <= '0;
      qCount              <= '0;
      credits             <= creditW'(`FAB_CREDITS);
      outFabricValidQ505H <= 1'b0;
   end else begin
      if (fabReqQ503H) wrPtr <= wrPtr + 1'b1;
      if (popQ504H) rdPtr <= rdPtr + 1'b1;
      qCount  <= qCount + {{qPtrW{1'b0}}, fabReqQ503H} - {{qPtrW{1'b0}}, popQ504H};
      credits <= credits + {{(creditW-1){1'b0}}, fabCreditReturn}
                         - {{(creditW-1){1'b0}}, popQ504H};   // one credit per response
      outFabricValidQ505H <= popQ504H;
   end
end

endmodule

// ==== logic/mini_core_top.sv ====
module mini_core_top (
   input  logic                         Clock,
   input  logic                         rst,
   input  mini_core_pkg::tTileId        localTileId,
   // ====================================================================
   // fabric
   // ====================================================================
   input  logic                         inFabricValidQ503H,
   input  var mini_core_pkg::tTileTrans inFabricQ503H,
   output logic                         miniCoreReady,
   output logic                         outFabricValidQ505H,
   output mini_core_pkg::tTileTrans     outFabricQ505H,
   input  logic                         fabCreditReturn      // one credit per pulse
);

logic                       run;                   // mem wrap to core
logic                       readyQ101H;            // to i-fetch
logic [31:0]                pcQ100H;               // to i-fetch
logic [31:0]                preInstructionQ101H;   // from i-fetch
logic                       dMemReady;             // from data port
logic [31:0]                dMemRdRspQ104H;        // from data port
mini_core_pkg::tCore2MemReq core2DmemReqQ103H;     // to data port

mini_core miniCore (
   .Clock               (Clock),
   .rst                 (rst),
   .run                 (run),
   .readyQ101H          (readyQ101H),
   .pcQ100H             (pcQ100H),
   .preInstructionQ101H (preInstructionQ101H),
   .dMemReady           (dMemReady),
   .core2DmemReqQ103H   (core2DmemReqQ103H),
   .dMemRdRspQ104H      (dMemRdRspQ104H)
);

mini_mem_wrap miniMemWrap (
   .Clock               (Clock),
   .rst                 (rst),
   .localTileId         (localTileId),
   .readyQ101H          (readyQ101H),           // core side
   .pcQ100H             (pcQ100H),
   .preInstructionQ101H (preInstructionQ101H),
   .core2DmemReqQ103H   (core2DmemReqQ103H),
   .dMemRdRspQ104H      (dMemRdRspQ104H),
   .dMemReady           (dMemReady),
   .run                 (run),
   .inFabricValidQ503H  (inFabricValidQ503H),   // fabric side
   .inFabricQ503H       (inFabricQ503H),
   .miniCoreReady       (miniCoreReady),
   .outFabricValidQ505H (outFabricValidQ505H),
   .outFabricQ505H      (outFabricQ505H),
   .fabCreditReturn     (fabCreditReturn)
);

endmodule

// ==== verif/mini_core_assertions.sv ====
`include "mini_core_macros.svh"

module mini_core_assertions (
   input logic                       Clock,
   input logic                       rst,
   input mini_core_pkg::tTileId      localTileId,
   input logic                       inFabricValidQ503H,
   input mini_core_pkg::tTileTrans   inFabricQ503H,
   input logic                       miniCoreReady,
   input logic                       outFabricValidQ505H,
   input mini_core_pkg::tTileTrans   outFabricQ505H,
   input logic                       fabCreditReturn,
   input mini_core_pkg::tCore2MemReq core2DmemReqQ103H,   // core stores feed the shadow
   input logic                       dMemReady
);

int                       errCount = 0;                    // read by the testbench
logic [31:0]              shadow [`MEM_DEPTH];
logic                     runShadow;
mini_core_pkg::tTileTrans expQ [`RSP_Q_DEPTH + 1];         // responses owed, in order
int                       expWr;
int                       expRd;
int                       expCount;
int                       creditCnt;                       // credits the tile may still use
logic                     acceptQ503H;
logic                     isWr;
mini_core_pkg::tTileTrans expNew;
mini_core_pkg::tTileTrans expHead;

initial begin
   for (int i = 0; i < `MEM_DEPTH; i++) shadow[i] = 32'd0;
end

assign isWr        = inFabricQ503H.opcode == mini_core_pkg::FAB_WR_REQ;
assign acceptQ503H = inFabricValidQ503H && miniCoreReady && (inFabricQ503H.dstId == localTileId)
                  && (isWr || (inFabricQ503H.opcode == mini_core_pkg::FAB_RD_REQ));
assign expHead     = expQ[expRd];

always_comb begin
   expNew.opcode  = isWr ? mini_core_pkg::FAB_WR_ACK : mini_core_pkg::FAB_RD_RSP;
   expNew.srcId   = localTileId;                 // ids swap
   expNew.dstId   = inFabricQ503H.srcId;
   expNew.address = inFabricQ503H.address;
   if (isWr) expNew.data = inFabricQ503H.data;   // ack echoes
   else if (inFabricQ503H.address == `CTRL_ADDR) expNew.data = {31'd0, runShadow};
   else expNew.data = shadow[inFabricQ503H.address[7:0]];
end

// ====================================================================
// bookkeeping
// ====================================================================
always @(posedge Clock) begin
   if (rst) begin
      expWr     <= 0;
      expRd     <= 0;
      expCount  <= 0;
      creditCnt <= `FAB_CREDITS;
      runShadow <= 1'b0;
   end else begin
      if (acceptQ503H) begin
         expQ[expWr] <= expNew;
         expWr       <= (expWr + 1) % (`RSP_Q_DEPTH + 1);
         if (isWr && inFabricQ503H.address == `CTRL_ADDR) runShadow <= inFabricQ503H.data[0];
         else if (isWr) shadow[inFabricQ503H.address[7:0]] <= inFabricQ503H.data;
      end else if (core2DmemReqQ103H.wrEn && dMemReady) begin
         shadow[core2DmemReqQ103H.address[9:2]] <= core2DmemReqQ103H.wrData;
      end
      if (outFabricValidQ505H) expRd <= (expRd + 1) % (`RSP_Q_DEPTH + 1);
      expCount  <= expCount + int'(acceptQ503H) - int'(outFabricValidQ505H);
      creditCnt <= creditCnt + int'(fabCreditReturn) - int'(outFabricValidQ505H);
   end
end

// ====================================================================
// checks
// ====================================================================
aResetIdle: assert property (@(posedge Clock) $fell(rst) |-> !outFabricValidQ505H && miniCoreReady)
   else begin errCount++; $error("tile not idle after reset"); end

aNoStray: assert property (@(posedge Clock) disable iff (rst) outFabricValidQ505H |-> expCount != 0)
   else begin errCount++; $error("response sent with no request accepted"); end

aRspMatch: assert property (@(posedge Clock) disable iff (rst)
   outFabricValidQ505H |-> outFabricQ505H == expHead)
   else begin
      errCount++;
      $error("FAIL t=%0t outFabricQ505H exp %h got %h", $time, expHead, outFabricQ505H);
   end

aCredit: assert property (@(posedge Clock) disable iff (rst) outFabricValidQ505H |-> creditCnt != 0)
   else begin errCount++; $error("response sent with no credit left"); end

aNoLoss: assert property (@(posedge Clock) disable iff (rst) expCount <= `RSP_Q_DEPTH)
   else begin errCount++; $error("more responses owed than the queue can hold"); end

// queued entries exclude the one on the output
aBackPressure: assert property (@(posedge Clock) disable iff (rst)
   (expCount - int'(outFabricValidQ505H)) >= (`RSP_Q_DEPTH - 1) |-> !miniCoreReady)
   else begin errCount++; $error("FAIL t=%0t miniCoreReady exp 0 got %b", $time, miniCoreReady); end

endmodule

bind mini_core_top mini_core_assertions chk (
   .Clock               (Clock),
   .rst                 (rst),
   .localTileId         (localTileId),
   .inFabricValidQ503H  (inFabricValidQ503H),
   .inFabricQ503H       (inFabricQ503H),
   .miniCoreReady       (miniCoreReady),
   .outFabricValidQ505H (outFabricValidQ505H),
   .outFabricQ505H      (outFabricQ505H),
   .fabCreditReturn     (fabCreditReturn),
   .core2DmemReqQ103H   (core2DmemReqQ103H),
   .dMemReady           (dMemReady)
);

// ==== verif/mini_core_tb.sv ====
`include "mini_core_macros.svh"

module mini_core_tb;

localparam int watchCycles = 5 * 400 + 500;   // five tests plus margin
localparam mini_core_pkg::tTileId myId = 4'h3;

logic                     Clock;
logic                     rst;
mini_core_pkg::tTileId    localTileId;
logic                     inFabricValidQ503H;
mini_core_pkg::tTileTrans inFabricQ503H;
logic                     miniCoreReady;
logic                     outFabricValidQ505H;
mini_core_pkg::tTileTrans outFabricQ505H;
logic                     fabCreditReturn;

int                       seed = 32'he266_6b4f;
int                       rspCount = 0;
int                       owed = 0;              // credits not yet handed back
logic                     returnOn = 1'b1;
mini_core_pkg::tTileTrans lastRsp;
int                       localFails = 0;
int                       passed = 0;
int                       failed = 0;

mini_core_top uut (.*);

initial begin
   Clock = 1'b0;
   forever #20 Clock = ~Clock;
end

// ====================================================================
// response monitor and credit return
// ====================================================================
always @(negedge Clock) begin
   if (outFabricValidQ505H) begin
      rspCount++;
      owed++;
      lastRsp = outFabricQ505H;
   end
end

always @(posedge Clock) begin
   if (returnOn && owed > 0) begin
      fabCreditReturn <= 1'b1;
      owed--;
   end else begin
      fabCreditReturn <= 1'b0;
   end
end

initial begin
   #(watchCycles * 40);
   $display("watchdog expired, run did not finish");
   $display("RESULT: FAIL");
   $finish;
end

// drives one request until it is accepted or maxWait cycles pass
task automatic sendReq(input mini_core_pkg::tFabOpcode op, input mini_core_pkg::tTileId dst,
                       input logic [31:0] addr, input logic [31:0] data,
                       input int maxWait, output bit accepted);
   accepted = 1'b0;
   @(posedge Clock);
   inFabricValidQ503H    <= 1'b1;
   inFabricQ503H.opcode  <= op;
   inFabricQ503H.srcId   <= 4'h9;
   inFabricQ503H.dstId   <= dst;
   inFabricQ503H.address <= addr;
   inFabricQ503H.data    <= data;
   for (int i = 0; i < maxWait && !accepted; i++) begin
      @(negedge Clock);
      if (miniCoreReady) accepted = 1'b1;   // taken at next rising edge
      else @(posedge Clock);
   end
   if (accepted) @(posedge Clock);
   inFabricValidQ503H <= 1'b0;
endtask

task automatic waitRsp(input int target, input string what);
   int n;
   n = 0;
   while (rspCount < target && n < 100) begin
      @(negedge Clock);
      n++;
   end
   if (rspCount < target) begin
      $display("%s: timed out waiting for fabric responses", what);
      localFails++;
   end
endtask

task automatic endTest(input string name, input int failsBefore);
   if (localFails + uut.chk.errCount > failsBefore) begin
      failed++;
      $display("test %s failed", name);
   end else begin
      passed++;
      $display("test %s passed", name);
   end
endtask

// ====================================================================
// tests
// ====================================================================
initial begin
   logic [31:0] prog [7];
   logic [31:0] wrAddr [4];
   logic [31:0] addr;
   bit          ok;
   int          base;
   int          acc;
   int          tries;

   prog[0] = 32'h0000_0093;   // addi x1, x0, 0
   prog[1] = 32'h0050_0113;   // addi x2, x0, 5
   prog[2] = 32'h0020_80B3;   // add  x1, x1, x2
   prog[3] = 32'hFFF1_0113;   // addi x2, x2, -1
   prog[4] = 32'hFE01_1CE3;   // bne  x2, x0, -8
   prog[5] = 32'h1810_2823;   // sw   x1, 400(x0) into word 100
   prog[6] = 32'h0000_9063;   // bne  x1, x0, 0 spins here

   rst                = 1'b1;
   localTileId        = myId;
   inFabricValidQ503H = 1'b0;
   inFabricQ503H      = '0;
   fabCreditReturn    = 1'b0;
   repeat (3) @(posedge Clock);
   rst <= 1'b0;

   base = 0;
   repeat (3) @(posedge Clock);
   endTest("reset", base);

   base = localFails + uut.chk.errCount;
   for (int i = 0; i < 4; i++) begin
      addr = ($random(seed) & 32'h7F) + 32'd101;   // clear of program and result word
      wrAddr[i] = addr;
      sendReq(mini_core_pkg::FAB_WR_REQ, myId, addr, $random(seed), 20, ok);
      sendReq(mini_core_pkg::FAB_RD_REQ, myId, addr, 32'd0, 20, ok);
   end
   waitRsp(8, "readback");
   endTest("readback", base);

   base = localFails + uut.chk.errCount;
   acc  = rspCount;
   sendReq(mini_core_pkg::FAB_RD_REQ, myId + 4'd1, 32'd110, 32'd0, 20, ok);
   repeat (10) @(posedge Clock);
   if (rspCount != acc) begin
      $display("FAIL t=%0t rspCount exp %0d got %0d", $time, acc, rspCount);
      localFails++;
   end
   endTest("other_dest", base);

   base     = localFails + uut.chk.errCount;
   returnOn = 1'b0;                                // hold credits back
   acc      = 0;
   tries    = rspCount;
   for (int i = 0; i < 6; i++) begin
      sendReq(mini_core_pkg::FAB_RD_REQ, myId, wrAddr[i % 4], 32'd0, 4, ok);
      acc += int'(ok);
   end
   if (acc >= 6) begin
      $display("credits withheld but every request was accepted");
      localFails++;
   end
   returnOn = 1'b1;
   waitRsp(tries + acc, "credits");
   endTest("credits", base);

   base = localFails + uut.chk.errCount;
   acc  = rspCount;
   for (int i = 0; i < 7; i++) sendReq(mini_core_pkg::FAB_WR_REQ, myId, i, prog[i], 20, ok);
   sendReq(mini_core_pkg::FAB_WR_REQ, myId, 32'd100, 32'd0, 20, ok);
   sendReq(mini_core_pkg::FAB_WR_REQ, myId, `CTRL_ADDR, 32'd1, 20, ok);
   waitRsp(acc + 9, "program load");
   tries = 0;
   lastRsp.data = 32'd0;
   while (lastRsp.data != 32'd15 && tries < 20) begin
      repeat (10) @(posedge Clock);
      acc = rspCount;
      sendReq(mini_core_pkg::FAB_RD_REQ, myId, 32'd100, 32'd0, 20, ok);
      waitRsp(acc + 1, "program result");
      tries++;
   end
   if (lastRsp.data != 32'd15) begin
      $display("FAIL t=%0t outFabricQ505H.data exp %0d got %0d", $time, 15, lastRsp.data);
      localFails++;
   end
   endTest("program", base);

   repeat (5) @(posedge Clock);
   $display("tests passed %0d failed %0d", passed, failed);
   if (failed == 0 && localFails + uut.chk.errCount == 0) begin
      $display("RESULT: PASS");
   end else begin
      $display("RESULT: FAIL");
   end
   $finish;
end

endmodule

// ==== mini_core_top.f ====
+incdir+logic
logic/mini_core_pkg.sv
logic/mini_core.sv
logic/mini_mem_wrap.sv
logic/mini_core_top.sv
verif/mini_core_assertions.sv
verif/mini_core_tb.sv

// ==== Makefile ====
# Verilator flow for the mini core tile

VERILATOR ?= verilator
TB_TOP    ?= mini_core_tb
RTL_TOP   ?= mini_core_top
FLIST     ?= mini_core_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
PASS_STR  ?= RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(FLIST) $(shell grep -v '^+' $(FLIST)) logic/mini_core_macros.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)
